/* flist.f */
rtl/audio_pkg.sv
rtl/reg_bus_if.sv
rtl/reg_bus_mux.sv
rtl/led_runner.sv
rtl/fir_filter.sv
rtl/i2s_codec_port.sv
rtl/audio_subsys_top.sv
tests/tb_audio_subsys.sv

/* rtl/audio_pkg.sv */
package audio_pkg;

  // Audio data path
  localparam int unsigned SAMPLE_W  = 16;
  localparam int unsigned ACC_W     = 32;
  localparam int unsigned N_TAPS    = 4;
  localparam int unsigned TAP_W     = $clog2(N_TAPS);
  localparam int unsigned COEF_FRAC = 15;  // Q1.15 coefficients

  // Register bus
  localparam int unsigned ADDR_W = 8;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned OFFS_W = 4;                // Register offset inside a device
  localparam int unsigned SEL_W  = ADDR_W - OFFS_W;  // Device select in the upper bits

  localparam logic [SEL_W-1:0] DEV_SEL_LED = SEL_W'(0);
  localparam logic [SEL_W-1:0] DEV_SEL_FIR = SEL_W'(1);

  // LED runner registers
  localparam logic [OFFS_W-1:0] LED_REG_CTRL   = OFFS_W'(0);
  localparam logic [OFFS_W-1:0] LED_REG_PERIOD = OFFS_W'(1);

  // FIR registers, coefficient k sits at FIR_REG_COEF0 + k
  localparam logic [OFFS_W-1:0] FIR_REG_COEF0 = OFFS_W'(0);
  localparam logic [OFFS_W-1:0] FIR_REG_COUNT = OFFS_W'(8);

  // Codec clocking, one frame is 2 * BCLK_HALF * FRAME_BITS clk_i cycles
  localparam int unsigned BCLK_HALF  = 4;
  localparam int unsigned MCLK_HALF  = 1;
  localparam int unsigned FRAME_BITS = 32;
  localparam int unsigned BCLK_PH_W  = $clog2(2 * BCLK_HALF);
  localparam int unsigned MCLK_CNT_W = $clog2(MCLK_HALF) + 1;
  localparam int unsigned BIT_CNT_W  = $clog2(FRAME_BITS);

  typedef enum logic [1:0] {
    FIR_IDLE,
    FIR_MAC,
    FIR_DONE
  } fir_state_e;

  typedef enum logic [2:0] {
    MUX_INIT,  // Held in reset, no requests taken
    MUX_IDLE,
    MUX_LED,
    MUX_FIR,
    MUX_ERR    // Mux answers an unmapped address itself
  } mux_state_e;

endpackage

/* rtl/audio_subsys_top.sv */
`timescale 1ns/1ps

module audio_subsys_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         req_valid_i,
  input  logic                         req_we_i,
  input  logic [audio_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [audio_pkg::DATA_W-1:0] req_wdata_i,
  input  logic                         rsp_ready_i,
  output logic                         req_ready_o,
  output logic                         rsp_valid_o,
  output logic [audio_pkg::DATA_W-1:0] rsp_rdata_o,
  output logic                         rsp_err_o,
  output logic [7:0]                   led_o,
  output logic                         ac_mclk_o,
  output logic                         ac_bclk_o,
  output logic                         ac_lrclk_o,
  output logic                         ac_dac_sdata_o,
  input  logic                         ac_adc_sdata_i
);
  import audio_pkg::*;

  reg_bus_if host_bus ();
  reg_bus_if led_bus ();
  reg_bus_if fir_bus ();

  logic                rx_valid;
  logic [SAMPLE_W-1:0] rx_sample;
  logic                y_valid;
  logic [SAMPLE_W-1:0] y_sample;

  // External host side of the bus
  assign host_bus.req_valid = req_valid_i;
  assign host_bus.req_we    = req_we_i;
  assign host_bus.req_addr  = req_addr_i;
  assign host_bus.req_wdata = req_wdata_i;
  assign host_bus.rsp_ready = rsp_ready_i;
  assign req_ready_o        = host_bus.req_ready;
  assign rsp_valid_o        = host_bus.rsp_valid;
  assign rsp_rdata_o        = host_bus.rsp_rdata;
  assign rsp_err_o          = host_bus.rsp_err;

  reg_bus_mux bus_mux_i (
    .clk_i,
    .arst_n_i,
    .host    (host_bus),
    .led_dev (led_bus),
    .fir_dev (fir_bus)
  );

  led_runner led_runner_i (
    .clk_i,
    .arst_n_i,
    .bus   (led_bus),
    .led_o (led_o)
  );

  fir_filter fir_filter_i (
    .clk_i,
    .arst_n_i,
    .bus         (fir_bus),
    .rx_valid_i  (rx_valid),
    .rx_sample_i (rx_sample),
    .y_valid_o   (y_valid),
    .y_sample_o  (y_sample)
  );

  i2s_codec_port codec_port_i (
    .clk_i,
    .arst_n_i,
    .mclk_o      (ac_mclk_o),
    .bclk_o      (ac_bclk_o),
    .lrclk_o     (ac_lrclk_o),
    .adc_sdata_i (ac_adc_sdata_i),
    .dac_sdata_o (ac_dac_sdata_o),
    .rx_valid_o  (rx_valid),
    .rx_sample_o (rx_sample),
    .tx_valid_i  (y_valid),   // Filtered result goes out next frame
    .tx_sample_i (y_sample)
  );

endmodule

/* rtl/fir_filter.sv */
`timescale 1ns/1ps

module fir_filter (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  reg_bus_if.device                      bus,
  input  logic                           rx_valid_i,
  input  logic [audio_pkg::SAMPLE_W-1:0] rx_sample_i,
  output logic                           y_valid_o,
  output logic [audio_pkg::SAMPLE_W-1:0] y_sample_o
);
  import audio_pkg::*;

  fir_state_e                 state_q;
  logic signed [SAMPLE_W-1:0] coef_q [N_TAPS];
  logic signed [SAMPLE_W-1:0] hist_q [N_TAPS];  // Index 0 holds the newest sample
  logic [TAP_W-1:0]           tap_q;
  logic signed [ACC_W-1:0]    acc_q;
  logic signed [ACC_W-1:0]    prod;
  logic signed [ACC_W-1:0]    acc_shr;
  logic [DATA_W-1:0]          count_q;
  logic                       y_valid_q;
  logic [SAMPLE_W-1:0]        y_sample_q;

  logic              run_q;
  logic              rsp_valid_q;
  logic              rsp_err_q;
  logic [DATA_W-1:0] rsp_rdata_q;
  logic [OFFS_W-1:0] off;
  logic [OFFS_W-1:0] coef_off;
  logic [TAP_W-1:0]  coef_idx;
  logic              is_coef;
  logic              is_count;
  logic              accept;

  // Register decode
  assign off      = bus.req_addr[OFFS_W-1:0];
  assign coef_off = off - FIR_REG_COEF0;
  assign is_coef  = (coef_off < OFFS_W'(N_TAPS));
  assign coef_idx = coef_off[TAP_W-1:0];
  assign is_count = (off == FIR_REG_COUNT);
  assign accept   = bus.req_valid && bus.req_ready;

  assign bus.req_ready = run_q && !rsp_valid_q;
  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rsp_rdata_q;
  assign bus.rsp_err   = rsp_err_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
      for (int k = 0; k < N_TAPS; k++) coef_q[k] <= '0;
    end else begin
      run_q <= 1'b1;
      if (accept) begin
        rsp_valid_q <= 1'b1;
        // Sample count is read-only
        rsp_err_q   <= bus.req_we ? !is_coef : !(is_coef || is_count);
        if (bus.req_we && is_coef) coef_q[coef_idx] <= bus.req_wdata[SAMPLE_W-1:0];
      end else if (bus.rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (is_coef) rsp_rdata_q <= {{(DATA_W-SAMPLE_W){1'b0}}, coef_q[coef_idx]};
      else if (is_count) rsp_rdata_q <= count_q;
      else rsp_rdata_q <= '0;
    end
  end

  // One tap per cycle, signed 16x16 into the 32-bit accumulator
  assign prod    = coef_q[tap_q] * hist_q[tap_q];
  assign acc_shr = acc_q >>> COEF_FRAC;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= FIR_IDLE;
      tap_q     <= '0;
      acc_q     <= '0;
      count_q   <= '0;
      y_valid_q <= 1'b0;
      for (int k = 0; k < N_TAPS; k++) hist_q[k] <= '0;
    end else begin
      y_valid_q <= 1'b0;
      case (state_q)
        FIR_IDLE: begin
          if (rx_valid_i) begin
            hist_q[0] <= rx_sample_i;
            for (int k = 1; k < N_TAPS; k++) hist_q[k] <= hist_q[k-1];
            acc_q   <= '0;
            tap_q   <= '0;
            state_q <= FIR_MAC;
          end
        end
        FIR_MAC: begin
          acc_q <= acc_q + prod;
          tap_q <= tap_q + 1'b1;
          if (tap_q == TAP_W'(N_TAPS - 1)) state_q <= FIR_DONE;
        end
        FIR_DONE: begin
          y_valid_q <= 1'b1;
          count_q   <= count_q + 1'b1;
          state_q   <= FIR_IDLE;
        end
        default: state_q <= FIR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == FIR_DONE) y_sample_q <= acc_shr[SAMPLE_W-1:0];  // Truncate, no saturation
  end

  assign y_valid_o  = y_valid_q;
  assign y_sample_o = y_sample_q;

  // Codec delivers one sample per frame, far slower than the MAC loop
  rx_only_when_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rx_valid_i |-> state_q == FIR_IDLE)
    else $error("Sample strobe arrived while the FIR was busy");

endmodule

/* rtl/i2s_codec_port.sv */
`timescale 1ns/1ps

module i2s_codec_port (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  output logic                           mclk_o,
  output logic                           bclk_o,
  output logic                           lrclk_o,
  input  logic                           adc_sdata_i,
  output logic                           dac_sdata_o,
  output logic                           rx_valid_o,
  output logic [audio_pkg::SAMPLE_W-1:0] rx_sample_o,
  input  logic                           tx_valid_i,
  input  logic [audio_pkg::SAMPLE_W-1:0] tx_sample_i
);
  import audio_pkg::*;

  logic [MCLK_CNT_W-1:0] mclk_cnt_q;
  logic                  mclk_q;
  logic [BCLK_PH_W-1:0]  ph_q;       // Position inside one bit clock
  logic                  bclk_q;
  logic [BIT_CNT_W-1:0]  bit_q;      // Bit position in the frame, MSB is lrclk
  logic [BIT_CNT_W-1:0]  bit_nxt;
  logic                  rise_evt;
  logic                  fall_evt;
  logic                  left_word;
  logic [SAMPLE_W-1:0]   rx_shift_q;
  logic                  rx_valid_q;
  logic [SAMPLE_W-1:0]   tx_hold_q;
  logic [SAMPLE_W-1:0]   tx_shift_q;
  logic                  dac_q;

  assign rise_evt  = (ph_q == BCLK_PH_W'(BCLK_HALF - 1));
  assign fall_evt  = (ph_q == BCLK_PH_W'(2 * BCLK_HALF - 1));
  assign bit_nxt   = bit_q + 1'b1;
  assign left_word = !bit_q[BIT_CNT_W-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mclk_cnt_q <= '0;
      mclk_q     <= 1'b0;
      ph_q       <= '0;
      bclk_q     <= 1'b0;
      bit_q      <= '0;
      rx_valid_q <= 1'b0;
      tx_hold_q  <= '0;
      tx_shift_q <= '0;
      dac_q      <= 1'b0;
    end else begin
      // Master clock divider
      if (mclk_cnt_q == MCLK_CNT_W'(MCLK_HALF - 1)) begin
        mclk_cnt_q <= '0;
        mclk_q     <= ~mclk_q;
      end else begin
        mclk_cnt_q <= mclk_cnt_q + 1'b1;
      end

      // Bit clock and frame position
      if (fall_evt) ph_q <= '0;
      else ph_q <= ph_q + 1'b1;
      if (rise_evt) bclk_q <= 1'b1;
      else if (fall_evt) bclk_q <= 1'b0;

      // Strobe two cycles after the 16th left bit is sampled
      rx_valid_q <= (ph_q == BCLK_PH_W'(BCLK_HALF + 1)) &&
                    (bit_q == BIT_CNT_W'(SAMPLE_W - 1));

      if (tx_valid_i) tx_hold_q <= tx_sample_i;

      // Transmit changes on falling bclk, MSB first
      if (fall_evt) begin
        bit_q <= bit_nxt;
        if (bit_nxt == '0) begin
          dac_q      <= tx_hold_q[SAMPLE_W-1];
          tx_shift_q <= {tx_hold_q[SAMPLE_W-2:0], 1'b0};
        end else begin
          dac_q      <= tx_shift_q[SAMPLE_W-1];  // Drained to zero for the right word
          tx_shift_q <= {tx_shift_q[SAMPLE_W-2:0], 1'b0};
        end
      end
    end
  end

  // Left word only, sampled on rising bclk
  always_ff @(posedge clk_i) begin
    if (rise_evt && left_word) rx_shift_q <= {rx_shift_q[SAMPLE_W-2:0], adc_sdata_i};
  end

  assign mclk_o      = mclk_q;
  assign bclk_o      = bclk_q;
  assign lrclk_o     = bit_q[BIT_CNT_W-1];  // Low during the left word
  assign dac_sdata_o = dac_q;
  assign rx_valid_o  = rx_valid_q;
  assign rx_sample_o = rx_shift_q;  // Stable through the right word

endmodule

/* rtl/led_runner.sv */
`timescale 1ns/1ps

module led_runner (
  input  logic       clk_i,
  input  logic       arst_n_i,
  reg_bus_if.device  bus,
  output logic [7:0] led_o
);
  import audio_pkg::*;

  logic [1:0]        ctrl_q;  // [0] enable, [1] shift left
  logic [DATA_W-1:0] period_q;
  logic [DATA_W-1:0] step_q;
  logic [7:0]        pattern_q;
  logic              run_q;
  logic              rsp_valid_q;
  logic              rsp_err_q;
  logic [DATA_W-1:0] rsp_rdata_q;
  logic [OFFS_W-1:0] off;
  logic              accept;
  logic              is_ctrl;
  logic              is_period;

  assign off       = bus.req_addr[OFFS_W-1:0];
  assign is_ctrl   = (off == LED_REG_CTRL);
  assign is_period = (off == LED_REG_PERIOD);
  assign accept    = bus.req_valid && bus.req_ready;

  assign bus.req_ready = run_q && !rsp_valid_q;  // Back-pressure while a response waits
  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rsp_rdata_q;
  assign bus.rsp_err   = rsp_err_q;

  assign led_o = ctrl_q[0] ? pattern_q : 8'h00;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
      ctrl_q      <= '0;
      period_q    <= '0;
      step_q      <= '0;
      pattern_q   <= 8'h01;
    end else begin
      run_q <= 1'b1;
      if (accept) begin
        rsp_valid_q <= 1'b1;
        rsp_err_q   <= !(is_ctrl || is_period);
        if (bus.req_we && is_ctrl) ctrl_q <= bus.req_wdata[1:0];
        if (bus.req_we && is_period) period_q <= bus.req_wdata;
      end else if (bus.rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end

      if (!ctrl_q[0]) begin
        step_q    <= '0;
        pattern_q <= 8'h01;  // Restart from bit 0 on next enable
      end else if (step_q == period_q) begin
        step_q    <= '0;
        pattern_q <= ctrl_q[1] ? {pattern_q[6:0], pattern_q[7]}
                               : {pattern_q[0], pattern_q[7:1]};
      end else begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (is_ctrl) rsp_rdata_q <= {{(DATA_W-2){1'b0}}, ctrl_q};
      else if (is_period) rsp_rdata_q <= period_q;
      else rsp_rdata_q <= '0;
    end
  end

endmodule

/* rtl/reg_bus_if.sv */
`timescale 1ns/1ps

interface reg_bus_if;
  import audio_pkg::*;

  // Request channel
  logic              req_valid;
  logic              req_ready;
  logic              req_we;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;

  // Response channel
  logic              rsp_valid;
  logic              rsp_ready;
  logic [DATA_W-1:0] rsp_rdata;
  logic              rsp_err;

  modport host (
    output req_valid, req_we, req_addr, req_wdata, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata, rsp_err
  );

  modport device (
    input  req_valid, req_we, req_addr, req_wdata, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata, rsp_err
  );

endinterface

/* rtl/reg_bus_mux.sv */
`timescale 1ns/1ps

module reg_bus_mux (
  input  logic      clk_i,
  input  logic      arst_n_i,
  reg_bus_if.device host,
  reg_bus_if.host   led_dev,
  reg_bus_if.host   fir_dev
);
  import audio_pkg::*;

  mux_state_e       state_q;
  logic [SEL_W-1:0] sel;
  logic             sel_led;
  logic             sel_fir;
  logic             idle;

  assign sel     = host.req_addr[ADDR_W-1:OFFS_W];
  assign sel_led = (sel == DEV_SEL_LED);
  assign sel_fir = (sel == DEV_SEL_FIR);
  assign idle    = (state_q == MUX_IDLE);  // One transaction in flight over all devices

  // Request path, devices only see their own offset
  assign led_dev.req_valid = host.req_valid && idle && sel_led;
  assign led_dev.req_we    = host.req_we;
  assign led_dev.req_addr  = {{SEL_W{1'b0}}, host.req_addr[OFFS_W-1:0]};
  assign led_dev.req_wdata = host.req_wdata;
  assign fir_dev.req_valid = host.req_valid && idle && sel_fir;
  assign fir_dev.req_we    = host.req_we;
  assign fir_dev.req_addr  = {{SEL_W{1'b0}}, host.req_addr[OFFS_W-1:0]};
  assign fir_dev.req_wdata = host.req_wdata;

  always_comb begin
    if (!idle) host.req_ready = 1'b0;
    else if (sel_led) host.req_ready = led_dev.req_ready;
    else if (sel_fir) host.req_ready = fir_dev.req_ready;
    else host.req_ready = 1'b1;  // Unmapped, answered here
  end

  // Response path follows the recorded target
  always_comb begin
    host.rsp_valid = 1'b0;
    host.rsp_rdata = '0;
    host.rsp_err   = 1'b0;
    case (state_q)
      MUX_LED: begin
        host.rsp_valid = led_dev.rsp_valid;
        host.rsp_rdata = led_dev.rsp_rdata;
        host.rsp_err   = led_dev.rsp_err;
      end
      MUX_FIR: begin
        host.rsp_valid = fir_dev.rsp_valid;
        host.rsp_rdata = fir_dev.rsp_rdata;
        host.rsp_err   = fir_dev.rsp_err;
      end
      MUX_ERR: begin
        host.rsp_valid = 1'b1;
        host.rsp_err   = 1'b1;
      end
      default: ;
    endcase
  end

  assign led_dev.rsp_ready = host.rsp_ready && (state_q == MUX_LED);
  assign fir_dev.rsp_ready = host.rsp_ready && (state_q == MUX_FIR);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= MUX_INIT;
    end else begin
      case (state_q)
        MUX_INIT: state_q <= MUX_IDLE;
        MUX_IDLE: begin
          if (host.req_valid && host.req_ready) begin
            state_q <= sel_led ? MUX_LED : (sel_fir ? MUX_FIR : MUX_ERR);
          end
        end
        default: begin
          if (host.rsp_valid && host.rsp_ready) state_q <= MUX_IDLE;
        end
      endcase
    end
  end

  // Devices answer only what the mux has routed to them
  led_rsp_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    led_dev.rsp_valid |-> state_q == MUX_LED)
    else $error("LED device responded without an outstanding request");

  fir_rsp_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fir_dev.rsp_valid |-> state_q == MUX_FIR)
    else $error("FIR device responded without an outstanding request");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the audio subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_audio_subsys \
  -f flist.f \
  -Mdir "$BUILD_DIR" -o sim_audio > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/sim_audio" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$SIM_LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

/* tests/tb_audio_subsys.sv */
`timescale 1ns/1ps

module tb_audio_subsys;
  import audio_pkg::*;

  localparam int N_ONEHOT   = 8;
  localparam int N_RAND     = 20;
  localparam int LED_PERIOD = 3;
  localparam int FRAME_CYC  = 2 * BCLK_HALF * FRAME_BITS;
  // Coefficient writes may each wait up to a frame for a quiet slot
  localparam int FRAMES_USED = 3 * N_TAPS + N_ONEHOT + N_RAND + 16;
  localparam int TIMEOUT_CYC = FRAMES_USED * FRAME_CYC + 2000;
  localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 8'h25;

  logic              clk_i;
  logic              arst_n_i;
  logic              req_valid_i;
  logic              req_we_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [DATA_W-1:0] req_wdata_i;
  logic              rsp_ready_i;
  logic              req_ready_o;
  logic              rsp_valid_o;
  logic [DATA_W-1:0] rsp_rdata_o;
  logic              rsp_err_o;
  logic [7:0]        led_o;
  logic              ac_mclk_o;
  logic              ac_bclk_o;
  logic              ac_lrclk_o;
  logic              ac_dac_sdata_o;
  logic              ac_adc_sdata_i;

  int    errors = 0;
  int    checks = 0;
  int    tests = 0;
  int    test_err0 = 0;
  string cur_test = "reset";
  int    pos = 0;             // Frame bit position as seen by the codec model
  int    words_rx = 0;        // Left words delivered to the DUT
  int    frames_checked = 0;
  logic [31:0] lfsr_q = 32'h5342_52b4;

  logic [SAMPLE_W-1:0]        sample_q [$];
  logic [SAMPLE_W-1:0]        dac_q [$];
  logic [2*SAMPLE_W:0]        exp_q [$];  // {one-hot flag, sample, expected DAC word}
  logic signed [SAMPLE_W-1:0] coef_sh [N_TAPS];
  logic signed [SAMPLE_W-1:0] hist_sh [N_TAPS];

  audio_subsys_top audio_subsys_top_i (
    .clk_i,
    .arst_n_i,
    .req_valid_i,
    .req_we_i,
    .req_addr_i,
    .req_wdata_i,
    .rsp_ready_i,
    .req_ready_o,
    .rsp_valid_o,
    .rsp_rdata_o,
    .rsp_err_o,
    .led_o,
    .ac_mclk_o,
    .ac_bclk_o,
    .ac_lrclk_o,
    .ac_dac_sdata_o,
    .ac_adc_sdata_i
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [SAMPLE_W-1:0] rand16();
    logic [SAMPLE_W-1:0] v;
    logic                fb;
    v = '0;
    for (int i = 0; i < SAMPLE_W; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[SAMPLE_W-2:0], fb};
    end
    return v;
  endfunction

  function automatic logic [SAMPLE_W-1:0] fir_ref(input logic signed [SAMPLE_W-1:0] c [N_TAPS],
                                                  input logic signed [SAMPLE_W-1:0] x [N_TAPS]);
    longint acc;
    acc = 0;
    for (int k = 0; k < N_TAPS; k++) acc += longint'(c[k]) * longint'(x[k]);
    return acc[COEF_FRAC +: SAMPLE_W];  // Arithmetic shift, then truncate
  endfunction

  function automatic logic [ADDR_W-1:0] led_addr(input logic [OFFS_W-1:0] off);
    return {DEV_SEL_LED, off};
  endfunction

  function automatic logic [ADDR_W-1:0] fir_addr(input logic [OFFS_W-1:0] off);
    return {DEV_SEL_FIR, off};
  endfunction

  task automatic check_val(input string what, input logic [DATA_W-1:0] expv,
                           input logic [DATA_W-1:0] actv);
    checks++;
    if (actv != expv) begin
      errors++;
      $display("[ERROR] %s: %s expected %h, actual %h", cur_test, what, expv, actv);
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("Test %s finished with %0d error(s)", cur_test, errors - test_err0);
  endtask

  task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata,
                          output logic [DATA_W-1:0] rdata, output logic err);
    int lat;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    rsp_ready_i = 1'b1;
    #1;  // Decode settles before ready is looked at
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);  // Accepted on the rising edge in between
    req_valid_i = 1'b0;
    lat = 0;
    while (!rsp_valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    if (lat != 0) begin
      errors++;
      $display("Response to address %h came %0d cycles late", addr, lat);
    end
    rdata = rsp_rdata_o;
    err   = rsp_err_o;
    @(negedge clk_i);
    rsp_ready_i = 1'b0;
  endtask

  // Middle of the right word away from the FIR update
  task automatic wait_quiet_slot();
    @(negedge clk_i);
    while (pos < SAMPLE_W + 2 || pos > FRAME_BITS - 6) @(negedge clk_i);
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = words_rx + n;
    while (words_rx < target) @(negedge clk_i);
  endtask

  task automatic write_coef(input int k, input logic [SAMPLE_W-1:0] val);
    logic [DATA_W-1:0] rd;
    logic              err;
    wait_quiet_slot();
    bus_xfer(1'b1, fir_addr(FIR_REG_COEF0 + OFFS_W'(k)), {16'h0, val}, rd, err);
    coef_sh[k] = val;
    check_val($sformatf("error flag on coefficient %0d write", k), 0, 32'(err));
  endtask

  task automatic send_and_drain(input int n);
    for (int i = 0; i < n; i++) sample_q.push_back(rand16());
    while (sample_q.size() > 0) @(negedge clk_i);
    wait_frames(2);  // Last result goes out one frame later
  endtask

  task automatic watch_leds(input logic left, input int cycles);
    logic [7:0] prev;
    logic [7:0] cur;
    logic [7:0] nxt;
    int         last;
    logic       wrapped;
    prev    = led_o;
    last    = -1;
    wrapped = 1'b0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk_i);
      cur = led_o;
      if (!$onehot(cur)) begin
        errors++;
        $display("LED pattern %b is not one-hot", cur);
      end else if (cur != prev) begin
        nxt = left ? {prev[6:0], prev[7]} : {prev[0], prev[7:1]};
        check_val("LED step", 32'(nxt), 32'(cur));
        if (last >= 0) check_val("LED step interval", 32'(LED_PERIOD + 1), 32'(i - last));
        if ((left && prev == 8'h80) || (!left && prev == 8'h01)) wrapped = 1'b1;
        last = i;
      end
      prev = cur;
    end
    if (!wrapped) begin
      errors++;
      $display("LED pattern never wrapped around");
    end
  endtask

  // Codec model that mirrors the frame position from bclk and lrclk
  initial begin
    logic [SAMPLE_W-1:0] cur_x;
    logic [SAMPLE_W-1:0] dac_word;
    logic                bclk_prev;
    logic                onehot;
    cur_x          = '0;
    dac_word       = '0;
    bclk_prev      = 1'b0;
    ac_adc_sdata_i = 1'b0;
    for (int k = 0; k < N_TAPS; k++) hist_sh[k] = '0;
    exp_q.push_back('0);  // Frame 0 sends the reset value
    forever begin
      @(negedge clk_i);
      if (!arst_n_i) begin
        pos = 0;
      end else begin
        if (bclk_prev && !ac_bclk_o) begin
          pos = (pos + 1) % FRAME_BITS;
          if (pos == SAMPLE_W) begin  // Left word complete in the DUT
            for (int k = N_TAPS - 1; k > 0; k--) hist_sh[k] = hist_sh[k-1];
            hist_sh[0] = cur_x;
            onehot = (coef_sh[0] == 16'sh7FFF);
            for (int k = 1; k < N_TAPS; k++) if (coef_sh[k] != 0) onehot = 1'b0;
            exp_q.push_back({onehot, cur_x, fir_ref(coef_sh, hist_sh)});
            words_rx++;
          end
          if (pos == 0) cur_x = (sample_q.size() > 0) ? sample_q.pop_front() : '0;
        end
        if (!bclk_prev && ac_bclk_o && pos < SAMPLE_W) begin
          dac_word = {dac_word[SAMPLE_W-2:0], ac_dac_sdata_o};
          if (pos == SAMPLE_W - 1) dac_q.push_back(dac_word);
        end
        if (ac_lrclk_o != (pos >= SAMPLE_W)) begin
          errors++;
          $display("lrclk out of step at frame bit %0d", pos);
        end
      end
      bclk_prev = ac_bclk_o;
      ac_adc_sdata_i <= (pos < SAMPLE_W) ? cur_x[SAMPLE_W-1-pos] : 1'b0;
    end
  end

  // Master clock runs at half the clk_i rate once reset is released
  initial begin
    logic mclk_prev;
    logic mclk_ok;
    wait (arst_n_i === 1'b1);
    mclk_prev = ac_mclk_o;
    mclk_ok   = 1'b1;
    while (mclk_ok) begin
      @(negedge clk_i);
      if (ac_mclk_o == mclk_prev) begin
        errors++;
        $display("mclk stopped toggling at %0t", $time);
        mclk_ok = 1'b0;
      end
      mclk_prev = ac_mclk_o;
    end
  end

  // DAC words against the reference one frame behind the samples
  initial begin
    logic [SAMPLE_W-1:0] got;
    logic [2*SAMPLE_W:0] ent;
    int                  diff;
    forever begin
      @(negedge clk_i);
      while (dac_q.size() > 0 && exp_q.size() > 0) begin
        got = dac_q.pop_front();
        ent = exp_q.pop_front();
        checks++;
        if (got != ent[SAMPLE_W-1:0]) begin
          errors++;
          $display("[ERROR] %s: DAC frame %0d expected %h, actual %h",
                   cur_test, frames_checked, ent[SAMPLE_W-1:0], got);
        end
        if (ent[2*SAMPLE_W]) begin
          diff = int'($signed(ent[2*SAMPLE_W-1:SAMPLE_W])) - int'($signed(got));
          if (diff > 1 || diff < -1) begin
            errors++;
            $display("[ERROR] %s: DAC frame %0d expected about %h, actual %h",
                     cur_test, frames_checked, ent[2*SAMPLE_W-1:SAMPLE_W], got);
          end
        end
        frames_checked++;
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYC) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [DATA_W-1:0]   rd;
    logic                err;
    logic [SAMPLE_W-1:0] val [N_TAPS];
    int                  exp_cnt;
    int                  fc0;
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    rsp_ready_i = 1'b0;
    for (int k = 0; k < N_TAPS; k++) coef_sh[k] = '0;

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    check_val("outputs in reset", 0, 32'({rsp_valid_o, req_ready_o, led_o, ac_mclk_o,
                                          ac_bclk_o, ac_lrclk_o, ac_dac_sdata_o}));
    arst_n_i = 1'b1;
    end_test();

    start_test("register_readback");
    for (int k = 0; k < N_TAPS; k++) begin
      val[k] = rand16();
      write_coef(k, val[k]);
    end
    for (int k = 0; k < N_TAPS; k++) begin
      bus_xfer(1'b0, fir_addr(FIR_REG_COEF0 + OFFS_W'(k)), 0, rd, err);
      check_val($sformatf("coefficient %0d", k), {16'h0, val[k]}, rd);
      check_val("read error flag", 0, 32'(err));
    end
    bus_xfer(1'b1, led_addr(LED_REG_CTRL), 32'h2, rd, err);  // Shift left while still disabled
    bus_xfer(1'b1, led_addr(LED_REG_PERIOD), 32'h0000_1234, rd, err);
    bus_xfer(1'b0, led_addr(LED_REG_CTRL), 0, rd, err);
    check_val("LED control", 32'h2, rd);
    check_val("read error flag", 0, 32'(err));
    bus_xfer(1'b0, led_addr(LED_REG_PERIOD), 0, rd, err);
    check_val("LED period", 32'h0000_1234, rd);
    check_val("read error flag", 0, 32'(err));
    end_test();

    start_test("bus_errors");
    bus_xfer(1'b0, UNMAPPED_ADDR, 0, rd, err);
    check_val("unmapped read error flag", 1, 32'(err));
    check_val("unmapped read data", 0, rd);
    bus_xfer(1'b1, UNMAPPED_ADDR, 32'hFFFF_FFFF, rd, err);
    check_val("unmapped write error flag", 1, 32'(err));
    bus_xfer(1'b1, fir_addr(FIR_REG_COUNT), 32'h55, rd, err);
    check_val("count write error flag", 1, 32'(err));
    end_test();

    start_test("onehot_passthrough");
    write_coef(0, 16'h7FFF);
    for (int k = 1; k < N_TAPS; k++) write_coef(k, 16'h0000);
    send_and_drain(N_ONEHOT);
    end_test();

    start_test("random_fir");
    for (int k = 0; k < N_TAPS; k++) write_coef(k, rand16());
    fc0 = frames_checked;
    send_and_drain(N_RAND);
    if (frames_checked - fc0 < N_RAND) begin
      errors++;
      $display("Only %0d DAC frames were compared", frames_checked - fc0);
    end
    wait_quiet_slot();
    exp_cnt = words_rx;
    bus_xfer(1'b0, fir_addr(FIR_REG_COUNT), 0, rd, err);
    check_val("sample count", 32'(exp_cnt), rd);
    end_test();

    start_test("led_runner");
    bus_xfer(1'b1, led_addr(LED_REG_PERIOD), 32'(LED_PERIOD), rd, err);
    bus_xfer(1'b1, led_addr(LED_REG_CTRL), 32'h3, rd, err);
    watch_leds(1'b1, 48);
    bus_xfer(1'b1, led_addr(LED_REG_CTRL), 32'h0, rd, err);
    check_val("LEDs while disabled", 0, 32'(led_o));
    bus_xfer(1'b1, led_addr(LED_REG_CTRL), 32'h1, rd, err);
    watch_leds(1'b0, 48);
    bus_xfer(1'b1, led_addr(LED_REG_CTRL), 32'h0, rd, err);
    end_test();

    start_test("backpressure");
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_we_i    = 1'b0;
    req_addr_i  = led_addr(LED_REG_PERIOD);
    rsp_ready_i = 1'b0;
    #1;
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    repeat (6) begin
      if (!rsp_valid_o) begin
        errors++;
        $display("Response dropped while rsp_ready was low");
      end
      if (req_ready_o) begin
        errors++;
        $display("Request ready while a response was waiting");
      end
      @(negedge clk_i);
    end
    rsp_ready_i = 1'b1;
    check_val("held read data", 32'(LED_PERIOD), rsp_rdata_o);
    @(negedge clk_i);
    rsp_ready_i = 1'b0;
    check_val("response after release", 0, 32'(rsp_valid_o));
    check_val("request ready after release", 1, 32'(req_ready_o));
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) $display("TEST RESULT: PASS");
    else $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
